// ==== hw/cmd_consts.svh ====
`ifndef CMD_CONSTS_SVH
`define CMD_CONSTS_SVH

// bus widths
`define CMD_BYTE_W        8
`define CMD_WORD_W        32

// receive window depth in bytes
`define CMD_WINDOW_BYTES  13

//////////////////////////////////////////////////////////////
// command keywords, five ASCII characters each
//////////////////////////////////////////////////////////////
`define KW_HELLO  40'h68_65_6c_6c_6f  // hello
`define KW_R_DDR  40'h72_5f_64_64_72  // r_ddr
`define KW_W_DDR  40'h77_5f_64_64_72  // w_ddr
`define KW_NPUST  40'h6e_70_75_73_74  // npust

//////////////////////////////////////////////////////////////
// reply tags, four ASCII characters each
//////////////////////////////////////////////////////////////
`define TAG_HELL  32'h68_65_6c_6c  // hell
`define TAG_OWOR  32'h6f_77_6f_72  // owor
`define TAG_LDHH  32'h6c_64_68_68  // ldhh
`define TAG_RDDR  32'h72_64_64_72  // rddr
`define TAG_WDDR  32'h77_64_64_72  // wddr
`define TAG_INST  32'h69_6e_73_74  // inst

`endif

// ==== hw/cmd_pkg.sv ====
`include "cmd_consts.svh"

package cmd_pkg;

	typedef logic [`CMD_BYTE_W-1:0] byte_t;  // one uart byte
	typedef logic [`CMD_WORD_W-1:0] word_t;  // address, data or count

	// decoded command kind
	typedef enum logic [2:0]
	{
		cmd_none,
		cmd_hello,
		cmd_rd,
		cmd_wr,
		cmd_npu
	} cmd_kind_e;

	// one decoded command, valid while kind is not cmd_none
	typedef struct packed
	{
		cmd_kind_e kind;
		word_t     addr;  // r_ddr and w_ddr address
		word_t     arg;   // hello count, w_ddr data, npust word
	} cmd_t;

	//////////////////////////////////////////////////////////////
	// wishbone classic, master side and slave side
	//////////////////////////////////////////////////////////////
	typedef struct packed
	{
		logic  cyc;
		logic  stb;
		logic  we;
		word_t adr;
		word_t dat;
	} wb_req_t;

	typedef struct packed
	{
		logic  ack;
		word_t dat;
	} wb_rsp_t;

	typedef struct packed
	{
		logic  valid;
		word_t data;
	} rd_data_t;

	typedef struct packed
	{
		logic  valid;
		word_t word;
	} npu_inst_t;

endpackage

// ==== hw/cmd_receiver.sv ====
`timescale 1ns/1ps
`include "cmd_consts.svh"

module cmd_receiver
(
	input  logic           sys_clk,
	input  logic           sys_rst_n,
	input  cmd_pkg::byte_t rx_byte,
	input  logic           rx_ready,
	output logic           rx_pop,
	output cmd_pkg::cmd_t  cmd
);

	typedef enum logic [1:0]
	{
		st_wait,
		st_shift,
		st_pop,
		st_check
	} rx_state_e;

	rx_state_e state;

	cmd_pkg::byte_t [`CMD_WINDOW_BYTES-1:0] window;  // index 0 is the newest byte

	cmd_pkg::cmd_kind_e kind_dec;
	cmd_pkg::cmd_kind_e kind_q;
	cmd_pkg::word_t     addr_q;
	cmd_pkg::word_t     arg_q;

	//////////////////////////////////////////////////////////////
	// fifo pacing, four cycles per byte at best
	//////////////////////////////////////////////////////////////
	always_ff @(posedge sys_clk)
	begin
		if (!sys_rst_n)
			state <= st_wait;
		else
		begin
			case (state)
				st_wait:  if (rx_ready) state <= st_shift;
				st_shift: state <= st_pop;
				st_pop:   state <= st_check;
				default:  state <= st_wait;
			endcase
		end
	end

	assign rx_pop = (state == st_pop);

	always_ff @(posedge sys_clk)
	begin
		if (state == st_shift)
			window <= {window[`CMD_WINDOW_BYTES-2:0], rx_byte};
	end

	//////////////////////////////////////////////////////////////
	// keyword compare
	//////////////////////////////////////////////////////////////
	always_comb
	begin
		kind_dec = cmd_pkg::cmd_none;
		if (window[8:4] == `KW_HELLO)       // keyword, then 4 byte count
			kind_dec = cmd_pkg::cmd_hello;
		else if (window[8:4] == `KW_R_DDR)
			kind_dec = cmd_pkg::cmd_rd;
		else if (window[8:4] == `KW_NPUST)
			kind_dec = cmd_pkg::cmd_npu;
		else if (window[12:8] == `KW_W_DDR) // keyword, address, data
			kind_dec = cmd_pkg::cmd_wr;
	end

	// strobe lasts the one cycle after check
	always_ff @(posedge sys_clk)
	begin
		if (!sys_rst_n)
			kind_q <= cmd_pkg::cmd_none;
		else if (state == st_check)
			kind_q <= kind_dec;
		else
			kind_q <= cmd_pkg::cmd_none;
	end

	always_ff @(posedge sys_clk)
	begin
		if (state == st_check)
		begin
			addr_q <= (kind_dec == cmd_pkg::cmd_wr) ? window[7:4] : window[3:0];
			arg_q  <= window[3:0];
		end
	end

	assign cmd = '{kind: kind_q, addr: addr_q, arg: arg_q};

	// one pop per captured byte
	a_pop_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_pop |=> !rx_pop)
		else $error("rx_pop held for two cycles");

endmodule

// ==== hw/cmd_executor.sv ====
`timescale 1ns/1ps

module cmd_executor
(
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	input  cmd_pkg::cmd_t      cmd,
	output cmd_pkg::wb_req_t   wb_req,
	input  cmd_pkg::wb_rsp_t   wb_rsp,
	output cmd_pkg::rd_data_t  rd_data,
	output cmd_pkg::npu_inst_t npu_inst
);

	typedef enum logic [1:0]
	{
		st_idle,
		st_bus,
		st_npu
	} ex_state_e;

	ex_state_e state;

	logic           bus_act_q;  // drives cyc and stb
	logic           we_q;
	cmd_pkg::word_t adr_q;
	cmd_pkg::word_t dat_q;
	logic           rd_valid_q;
	cmd_pkg::word_t rd_word_q;
	logic           npu_valid_q;
	cmd_pkg::word_t npu_word_q;

	logic bus_cmd;

	assign bus_cmd = (cmd.kind == cmd_pkg::cmd_rd) || (cmd.kind == cmd_pkg::cmd_wr);

	//////////////////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////////////////
	always_ff @(posedge sys_clk)
	begin
		if (!sys_rst_n)
		begin
			state       <= st_idle;
			bus_act_q   <= 1'b0;
			rd_valid_q  <= 1'b0;
			npu_valid_q <= 1'b0;
		end
		else
		begin
			rd_valid_q  <= 1'b0;
			npu_valid_q <= 1'b0;
			case (state)
				st_idle:
				begin
					if (bus_cmd)
					begin
						bus_act_q <= 1'b1;
						state     <= st_bus;
					end
					else if (cmd.kind == cmd_pkg::cmd_npu)
					begin
						npu_valid_q <= 1'b1;  // pulse shows while in st_npu
						state       <= st_npu;
					end
				end
				st_bus:
				begin
					if (wb_rsp.ack)
					begin
						bus_act_q  <= 1'b0;
						rd_valid_q <= !we_q;
						state      <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// request fields, held for the whole cycle
	always_ff @(posedge sys_clk)
	begin
		if (state == st_idle && bus_cmd)
		begin
			adr_q <= cmd.addr;
			dat_q <= cmd.arg;
			we_q  <= (cmd.kind == cmd_pkg::cmd_wr);
		end
		if (state == st_bus && wb_rsp.ack)
			rd_word_q <= wb_rsp.dat;
		if (state == st_idle && cmd.kind == cmd_pkg::cmd_npu)
			npu_word_q <= cmd.arg;
	end

	assign wb_req   = '{cyc: bus_act_q, stb: bus_act_q, we: we_q, adr: adr_q, dat: dat_q};
	assign rd_data  = '{valid: rd_valid_q, data: rd_word_q};
	assign npu_inst = '{valid: npu_valid_q, word: npu_word_q};

	//////////////////////////////////////////////////////////////
	// bus checks
	//////////////////////////////////////////////////////////////
	a_stb_in_cyc: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wb_req.stb |-> (wb_req.cyc && state == st_bus))
		else $error("stb outside an active bus cycle");

	a_adr_stable: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(wb_req.stb && !wb_rsp.ack) |=> (wb_req.stb && $stable(wb_req.adr)))
		else $error("adr changed while waiting for ack");

endmodule

// ==== hw/reply_builder.sv ====
`timescale 1ns/1ps
`include "cmd_consts.svh"

module reply_builder
(
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  cmd_pkg::cmd_t     cmd,
	input  cmd_pkg::rd_data_t rd_data,
	input  logic              tx_ready,
	output cmd_pkg::word_t    tx_word,
	output logic              tx_valid
);

	typedef enum logic [2:0]
	{
		st_idle,
		st_banner,
		st_count,
		st_rd_tag,
		st_rd_data,
		st_ack_tag
	} tx_state_e;

	tx_state_e state;

	cmd_pkg::cmd_kind_e kind_q;
	cmd_pkg::word_t     arg_q;
	cmd_pkg::word_t     cnt_q;
	logic               tx_ready_q;  // permit, one cycle late
	logic               rd_pend_q;   // read word came before the rddr tag left
	cmd_pkg::word_t     rd_word_q;

	logic           send;
	cmd_pkg::word_t word_sel;

	//////////////////////////////////////////////////////////////
	// word select
	//////////////////////////////////////////////////////////////
	always_comb
	begin
		send     = 1'b0;
		word_sel = cnt_q;
		case (state)
			st_banner:
			begin
				send = tx_ready_q;
				case (cnt_q[1:0])
					2'd0:    word_sel = `TAG_HELL;
					2'd1:    word_sel = `TAG_OWOR;
					default: word_sel = `TAG_LDHH;
				endcase
			end
			st_count:
				send = tx_ready_q && (cnt_q != arg_q);  // counting words 0..n-1
			st_rd_tag:
			begin
				send     = tx_ready_q;
				word_sel = `TAG_RDDR;
			end
			st_rd_data:
			begin
				send     = rd_data.valid || (rd_pend_q && tx_ready_q);
				word_sel = rd_data.valid ? rd_data.data : rd_word_q;
			end
			st_ack_tag:
			begin
				send     = tx_ready_q;
				word_sel = (kind_q == cmd_pkg::cmd_wr) ? `TAG_WDDR : `TAG_INST;
			end
			default: send = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////
	// sequencing
	//////////////////////////////////////////////////////////////
	always_ff @(posedge sys_clk)
	begin
		if (!sys_rst_n)
		begin
			state      <= st_idle;
			cnt_q      <= '0;
			tx_ready_q <= 1'b0;
			tx_valid   <= 1'b0;
			rd_pend_q  <= 1'b0;
		end
		else
		begin
			tx_ready_q <= tx_ready;
			tx_valid   <= send;
			case (state)
				st_idle:
				begin
					cnt_q     <= '0;
					rd_pend_q <= 1'b0;
					case (cmd.kind)
						cmd_pkg::cmd_hello: state <= st_banner;
						cmd_pkg::cmd_rd:    state <= st_rd_tag;
						cmd_pkg::cmd_wr:    state <= st_ack_tag;
						cmd_pkg::cmd_npu:   state <= st_ack_tag;
						default:            state <= st_idle;
					endcase
				end
				st_banner:
				begin
					if (send)
					begin
						cnt_q <= (cnt_q == 2) ? '0 : cnt_q + 1'b1;
						if (cnt_q == 2)
							state <= st_count;
					end
				end
				st_count:
				begin
					if (cnt_q == arg_q)
						state <= st_idle;
					else if (send)
						cnt_q <= cnt_q + 1'b1;
				end
				st_rd_tag:
				begin
					if (rd_data.valid)
						rd_pend_q <= 1'b1;
					if (send)
						state <= st_rd_data;
				end
				default:
				begin
					if (send)
						state <= st_idle;  // single last word sent
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (state == st_idle && cmd.kind != cmd_pkg::cmd_none)
		begin
			kind_q <= cmd.kind;
			arg_q  <= cmd.arg;
		end
		if (state == st_rd_tag && rd_data.valid)
			rd_word_q <= rd_data.data;
		if (send)
			tx_word <= word_sel;
	end

	// only the read word may bypass the permit
	a_tx_permit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(tx_valid && !$past(state == st_rd_data)) |-> $past(tx_ready_q))
		else $error("tx_valid without permit");

endmodule

// ==== hw/cmd_parser_top.sv ====
`timescale 1ns/1ps

module cmd_parser_top
(
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	input  cmd_pkg::byte_t     rx_byte,
	input  logic               rx_ready,
	output logic               rx_pop,
	output cmd_pkg::wb_req_t   wb_req,
	input  cmd_pkg::wb_rsp_t   wb_rsp,
	output cmd_pkg::word_t     tx_word,
	output logic               tx_valid,
	input  logic               tx_ready,
	output cmd_pkg::npu_inst_t npu_inst,
	output logic               cmd_seen
);

	cmd_pkg::cmd_t     cmd;      // decoded strobe to both peers
	cmd_pkg::rd_data_t rd_data;  // executor to builder

	//////////////////////////////////////////////////////////////
	// peers
	//////////////////////////////////////////////////////////////
	cmd_receiver u_receiver
	(
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_ready  (rx_ready),
		.rx_pop    (rx_pop),
		.cmd       (cmd)
	);

	cmd_executor u_executor
	(
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cmd       (cmd),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.rd_data   (rd_data),
		.npu_inst  (npu_inst)
	);

	reply_builder u_builder
	(
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cmd       (cmd),
		.rd_data   (rd_data),
		.tx_ready  (tx_ready),
		.tx_word   (tx_word),
		.tx_valid  (tx_valid)
	);

	assign cmd_seen = (cmd.kind != cmd_pkg::cmd_none);  // one pulse per decoded command

endmodule

// ==== verification/tb_cmd_parser.sv ====
`timescale 1ns/1ps
`include "cmd_consts.svh"

module tb_cmd_parser;

	localparam int WAIT_LIMIT = 3000;  // cycles per wait loop

	logic               sys_clk;
	logic               sys_rst_n;
	cmd_pkg::byte_t     rx_byte;
	logic               rx_ready;
	logic               rx_pop;
	cmd_pkg::wb_req_t   wb_req;
	cmd_pkg::wb_rsp_t   wb_rsp;
	cmd_pkg::word_t     tx_word;
	logic               tx_valid;
	logic               tx_ready;
	cmd_pkg::npu_inst_t npu_inst;
	logic               cmd_seen;

	integer         seed;
	cmd_pkg::byte_t rx_q[$];                         // receive fifo contents
	cmd_pkg::word_t got_q[$];                        // words taken from tx
	cmd_pkg::word_t exp_q[$];                        // reference reply
	cmd_pkg::word_t mem[cmd_pkg::word_t];            // slave storage
	cmd_pkg::word_t ref_mem[cmd_pkg::word_t];        // reference image
	logic           pop_due;
	logic           in_cycle;
	int             wait_left;
	int             acc_cnt;   // acked bus cycles
	int             seen_cnt;
	int             npu_cnt;
	int             acc_exp;
	int             seen_exp;
	int             npu_exp;
	cmd_pkg::word_t npu_last;
	int             errors;
	int             checks;

	cmd_parser_top u_dut
	(
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_ready  (rx_ready),
		.rx_pop    (rx_pop),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.tx_word   (tx_word),
		.tx_valid  (tx_valid),
		.tx_ready  (tx_ready),
		.npu_inst  (npu_inst),
		.cmd_seen  (cmd_seen)
	);

	always #5 sys_clk = ~sys_clk;

	//////////////////////////////////////////////////////////////
	// fifo, memory slave and tx models driven 1 ns after each edge
	//////////////////////////////////////////////////////////////
	always @(posedge sys_clk)
	begin
		#1;
		if (sys_rst_n)
		begin
			if (tx_valid)
				got_q.push_back(tx_word);
			if (cmd_seen)
				seen_cnt++;
			if (npu_inst.valid)
			begin
				npu_cnt++;
				npu_last = npu_inst.word;
			end
		end
		if (pop_due)
			rx_q.delete(0);  // pop taken at this edge
		pop_due  = sys_rst_n && rx_pop;
		rx_ready = (rx_q.size() > 0) && (($random(seed) & 3) != 0);
		rx_byte  = (rx_q.size() > 0) ? rx_q[0] : 8'h00;
		tx_ready = ($random(seed) & 7) > 2;
		if (wb_rsp.ack)
		begin
			wb_rsp.ack = 1'b0;  // master drops stb after this edge
			in_cycle   = 1'b0;
		end
		else if (sys_rst_n && wb_req.cyc && wb_req.stb)
		begin
			if (!in_cycle)
			begin
				in_cycle  = 1'b1;
				wait_left = $random(seed) & 3;
			end
			if (wait_left == 0)
			begin
				acc_cnt++;
				if (wb_req.we)
					mem[wb_req.adr] = wb_req.dat;
				// unwritten words read back as their own address
				wb_rsp.dat = mem.exists(wb_req.adr) ? mem[wb_req.adr] : wb_req.adr;
				wb_rsp.ack = 1'b1;
			end
			else
				wait_left = wait_left - 1;
		end
	end

	task automatic check_value(input string name, input cmd_pkg::word_t expected,
		input cmd_pkg::word_t actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic end_run;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic push_word(input cmd_pkg::word_t w);
		for (int i = 3; i >= 0; i--)
			rx_q.push_back(w[i*8 +: 8]);  // most significant byte first
	endtask

	task automatic push_kw(input logic [39:0] k);
		for (int i = 4; i >= 0; i--)
			rx_q.push_back(k[i*8 +: 8]);
	endtask

	//////////////////////////////////////////////////////////////
	// waits
	//////////////////////////////////////////////////////////////
	task automatic wait_rx_empty;
		int i;
		i = 0;
		while (rx_q.size() != 0 && i < WAIT_LIMIT)
		begin
			@(posedge sys_clk);
			i++;
		end
		if (i >= WAIT_LIMIT)
		begin
			errors++;
			$display("timeout: the receiver stopped taking bytes from the fifo");
			end_run();
		end
	endtask

	task automatic wait_counts(input int words, input int acc, input int npu);
		int i;
		i = 0;
		while ((got_q.size() < words || acc_cnt < acc || npu_cnt < npu) && i < WAIT_LIMIT)
		begin
			@(posedge sys_clk);
			i++;
		end
		if (i >= WAIT_LIMIT)
		begin
			errors++;
			$display("timeout: reply words, bus cycles or npu pulses did not arrive");
			end_run();
		end
	endtask

	task automatic compare_reply(input string name);
		while (exp_q.size() > 0)
			check_value(name, exp_q.pop_front(), got_q.pop_front());
	endtask

	//////////////////////////////////////////////////////////////
	// commands and their reference replies
	//////////////////////////////////////////////////////////////
	task automatic run_hello(input int n);
		exp_q.push_back(`TAG_HELL);
		exp_q.push_back(`TAG_OWOR);
		exp_q.push_back(`TAG_LDHH);
		for (int i = 0; i < n; i++)
			exp_q.push_back(i);
		push_kw(`KW_HELLO);
		push_word(n);
		seen_exp++;
		wait_counts(exp_q.size(), acc_exp, npu_exp);
		compare_reply("hello");
	endtask

	task automatic run_write(input cmd_pkg::word_t a, input cmd_pkg::word_t d);
		ref_mem[a] = d;
		exp_q.push_back(`TAG_WDDR);
		push_kw(`KW_W_DDR);
		push_word(a);
		push_word(d);
		seen_exp++;
		acc_exp++;
		wait_counts(exp_q.size(), acc_exp, npu_exp);
		compare_reply("w_ddr");
		check_value("w_ddr memory", d, mem[a]);
	endtask

	task automatic run_read(input string name, input cmd_pkg::word_t a);
		exp_q.push_back(`TAG_RDDR);
		exp_q.push_back(ref_mem.exists(a) ? ref_mem[a] : a);
		push_kw(`KW_R_DDR);
		push_word(a);
		seen_exp++;
		acc_exp++;
		wait_counts(exp_q.size(), acc_exp, npu_exp);
		compare_reply(name);
	endtask

	task automatic run_npust(input cmd_pkg::word_t w);
		exp_q.push_back(`TAG_INST);
		push_kw(`KW_NPUST);
		push_word(w);
		seen_exp++;
		npu_exp++;
		wait_counts(exp_q.size(), acc_exp, npu_exp);
		compare_reply("npust");
		check_value("npust word", w, npu_last);
		check_value("npust pulses", npu_exp, npu_cnt);
	endtask

	// random bytes then a keyword with one bit flipped and an argument
	task automatic send_garbage;
		int          n;
		logic [39:0] k;
		n = 3 + ($unsigned($random(seed)) % 8);
		for (int i = 0; i < n; i++)
			rx_q.push_back(cmd_pkg::byte_t'($random(seed)));
		case ($unsigned($random(seed)) % 4)
			0:       k = `KW_HELLO;
			1:       k = `KW_R_DDR;
			2:       k = `KW_W_DDR;
			default: k = `KW_NPUST;
		endcase
		push_kw(k ^ (40'h1 << ($unsigned($random(seed)) % 40)));
		push_word($random(seed));
		wait_rx_empty();
		repeat (30) @(posedge sys_clk);
		check_value("garbage cmd_seen", seen_exp, seen_cnt);
		check_value("garbage bus cycles", acc_exp, acc_cnt);
		check_value("garbage reply words", 0, got_q.size());
	endtask

	initial
	begin
		cmd_pkg::word_t a;
		cmd_pkg::word_t d;
		seed      = 32'h4044_4be4;
		sys_clk   = 1'b0;
		sys_rst_n = 1'b0;
		rx_byte   = 8'h00;
		rx_ready  = 1'b0;
		tx_ready  = 1'b0;
		wb_rsp    = '0;
		pop_due   = 1'b0;
		in_cycle  = 1'b0;
		wait_left = 0;
		npu_last  = '0;
		acc_cnt   = 0;
		seen_cnt  = 0;
		npu_cnt   = 0;
		acc_exp   = 0;
		seen_exp  = 0;
		npu_exp   = 0;
		errors    = 0;
		checks    = 0;
		repeat (2) @(posedge sys_clk);
		#1 sys_rst_n = 1'b1;
		@(posedge sys_clk);
		for (int round = 0; round < 4; round++)
		begin
			send_garbage();
			run_hello($unsigned($random(seed)) % 9);
			a = $random(seed);
			d = $random(seed);
			run_write(a, d);
			run_read("r_ddr written", a);
			run_read("r_ddr fresh", $random(seed));  // preset value expected
			run_npust($random(seed));
		end
		repeat (30) @(posedge sys_clk);
		check_value("final reply words", 0, got_q.size());
		check_value("final cmd_seen", seen_exp, seen_cnt);
		check_value("final bus cycles", acc_exp, acc_cnt);
		check_value("final npust pulses", npu_exp, npu_cnt);
		end_run();
	end

endmodule

// ==== project.f ====
+incdir+hw
hw/cmd_pkg.sv
hw/cmd_receiver.sv
hw/cmd_executor.sv
hw/reply_builder.sv
hw/cmd_parser_top.sv
verification/tb_cmd_parser.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cmd_parser
FILELIST  ?= project.f

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hw/*.svh)
PASS    := *** TEST PASSED ***

.PHONY: all run clean

all: run

obj_dir/V%: $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS)'

clean:
	rm -rf obj_dir
